// ==== sources.f ====
verilog/rob_pkg.sv
verilog/tag_cam.sv
verilog/rob.sv
verilog/exec_pipe.sv
verilog/cdb_arbiter.sv
verilog/rob_subsystem.sv
bench/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module rob_tb -o rob_sim

output=$(./obj_dir/rob_sim) || { echo "$output"; exit 1; }
echo "$output"

if echo "$output" | grep -q "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi

// ==== bench/rob_tb.sv ====
`default_nettype none

module rob_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import rob_pkg::*;

	// Rough cycle counts per test, doubled by the watchdog
	localparam int CYCLE_BUDGET = 10 + 25 + 25 + 25 + 50 + 20 + 15;

	logic clock;
	logic rst_n;
	logic enable;
	logic branch_not_taken;
	dispatch_t [SS_SIZE-1:0] dispatch_in;
	issue_t alu_issue;
	issue_t mult_issue;
	logic alu_issue_ready;
	logic mult_issue_ready;
	rob_entry_t [SS_SIZE-1:0] retire_out;
	logic [ROB_IDX_W-1:0] free_rows_next;
	logic full;
	cdb_t cdb_out;

	rob_entry_t model_q[$];  // Program order, oldest first
	logic [PREG_W-1:0] inflight[$];
	logic [PREG_W-1:0] bcast_tag[$];
	int bcast_cyc[$];
	string test_name;
	int cycle_no;
	bit failed;
	bit alu_taken;
	bit mult_taken;
	bit alu_stall_seen;
	bit mult_stall_seen;

	rob_subsystem dut0 (
		.clock           (clock),
		.rst_n           (rst_n),
		.enable          (enable),
		.branch_not_taken(branch_not_taken),
		.dispatch_in     (dispatch_in),
		.alu_issue       (alu_issue),
		.mult_issue      (mult_issue),
		.alu_issue_ready (alu_issue_ready),
		.mult_issue_ready(mult_issue_ready),
		.retire_out      (retire_out),
		.free_rows_next  (free_rows_next),
		.full            (full),
		.cdb_out         (cdb_out)
	);

	always #20 clock = ~clock;

	initial begin
		repeat (CYCLE_BUDGET * 2) @(posedge clock);
		$display("Timeout: the tests did not finish within the cycle budget");
		$display("Simulation failed");
		$fatal(1);
	end

	task automatic report_failure(input string what);
		failed = 1'b1;
		$display("Test %s: %s", test_name, what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			failed = 1'b1;
			$display("ERROR test %s, %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic dispatch_t make_dispatch(input logic ready, input logic [PREG_W-1:0] idx);
		dispatch_t d;
		d.valid       = 1'b1;
		d.t_new.ready = ready;
		d.t_new.idx   = idx;
		d.t_old.ready = 1'b1;
		d.t_old.idx   = PREG_W'($urandom);
		d.halt        = 1'($urandom);
		d.inst        = $urandom;
		return d;
	endfunction

	// One cycle: check outputs mid-cycle against the model, then step to the next falling edge
	task automatic tick();
		rob_entry_t ent;
		int space;
		int n_ret;
		logic chain;
		bit found;
		#5;
		cycle_no++;
		check_value("full", 32'(model_q.size() == ROB_SIZE), 32'(full));
		if (!alu_issue_ready) alu_stall_seen = 1'b1;
		if (!mult_issue_ready) mult_stall_seen = 1'b1;
		if (branch_not_taken) begin
			check_value("cdb valid during flush", 32'(0), 32'(cdb_out.valid));
		end
		if (cdb_out.valid) begin
			found = 1'b0;
			for (int i = 0; i < inflight.size(); i++) begin
				if (!found && inflight[i] == cdb_out.idx) begin
					inflight.delete(i);
					found = 1'b1;
				end
			end
			if (!found) begin
				report_failure($sformatf("tag %0d on the CDB was not in flight", cdb_out.idx));
			end
			bcast_tag.push_back(cdb_out.idx);
			bcast_cyc.push_back(cycle_no);
			for (int i = 0; i < model_q.size(); i++) begin
				if (model_q[i].t_new.idx == cdb_out.idx) model_q[i].t_new.ready = 1'b1;
			end
		end

		// In-order retire from the head
		chain = enable && !branch_not_taken;
		n_ret = 0;
		for (int r = 0; r < SS_SIZE; r++) begin
			if (chain && r < model_q.size() && model_q[r].t_new.ready) begin
				check_value("retire busy", 32'(1), 32'(retire_out[r].busy));
				check_value("retire new tag", 32'(model_q[r].t_new.idx),
					32'(retire_out[r].t_new.idx));
				check_value("retire old tag", 32'(model_q[r].t_old.idx),
					32'(retire_out[r].t_old.idx));
				check_value("retire halt", 32'(model_q[r].halt), 32'(retire_out[r].halt));
				check_value("retire inst", model_q[r].inst, retire_out[r].inst);
				n_ret++;
			end else begin
				chain = 1'b0;
				check_value("empty lane busy", 32'(0), 32'(retire_out[r].busy));
				check_value("empty lane inst", NOOP_INST, retire_out[r].inst);
			end
		end
		repeat (n_ret) model_q.delete(0);

		// Dispatch into whatever space is left
		space = ROB_SIZE - model_q.size();
		chain = enable && !branch_not_taken;
		for (int d = 0; d < SS_SIZE; d++) begin
			if (chain && dispatch_in[d].valid && space > 0) begin
				ent = '0;
				ent.t_new = dispatch_in[d].t_new;
				ent.t_new.ready = dispatch_in[d].t_new.ready
					|| (cdb_out.valid && cdb_out.idx == dispatch_in[d].t_new.idx);
				ent.t_old = dispatch_in[d].t_old;
				ent.halt  = dispatch_in[d].halt;
				ent.inst  = dispatch_in[d].inst;
				ent.busy  = 1'b1;
				model_q.push_back(ent);
				space--;
			end else begin
				chain = 1'b0;
			end
		end

		if (branch_not_taken) begin
			model_q.delete();
			inflight.delete();
		end
		check_value("free rows next", branch_not_taken ? 32'(ROB_SIZE) : 32'(space),
			32'(free_rows_next));

		alu_taken  = alu_issue.valid && alu_issue_ready && !branch_not_taken;
		mult_taken = mult_issue.valid && mult_issue_ready && !branch_not_taken;
		if (alu_taken) inflight.push_back(alu_issue.idx);
		if (mult_taken) inflight.push_back(mult_issue.idx);

		@(negedge clock);
		dispatch_in      = '0;
		alu_issue        = '0;
		mult_issue       = '0;
		branch_not_taken = 1'b0;
	endtask

	task automatic check_idle();
		#5;
		check_value("idle free rows", 32'(ROB_SIZE), 32'(free_rows_next));
		check_value("idle full", 32'(0), 32'(full));
		check_value("idle lane 0 busy", 32'(0), 32'(retire_out[0].busy));
		check_value("idle lane 1 busy", 32'(0), 32'(retire_out[1].busy));
		check_value("idle cdb valid", 32'(0), 32'(cdb_out.valid));
		check_value("idle alu ready", 32'(1), 32'(alu_issue_ready));
		check_value("idle mult ready", 32'(1), 32'(mult_issue_ready));
		@(negedge clock);
	endtask

	task automatic wait_quiet(input int limit);
		int n;
		n = 0;
		while (model_q.size() != 0 || inflight.size() != 0) begin
			if (n == limit) report_failure("buffer or lanes did not drain in time");
			tick();
			n++;
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		model_q.delete();
		inflight.delete();
		check_idle();
	endtask

	task automatic fill_and_drain();
		logic [PREG_W-1:0] head_tag;
		test_name = "fill_and_drain";
		head_tag  = PREG_W'($urandom);
		// Only the oldest waits, so the buffer can fill up
		for (int p = 0; p < 4; p++) begin
			dispatch_in[0] = make_dispatch(p != 0, p == 0 ? head_tag : PREG_W'($urandom));
			dispatch_in[1] = make_dispatch(1'b1, PREG_W'($urandom));
			tick();
		end
		check_value("full after fill", 32'(1), 32'(full));
		alu_issue = '{1'b1, head_tag};
		tick();
		wait_quiet(10);
		check_idle();
	endtask

	task automatic ooo_complete();
		logic [PREG_W-1:0] base;
		logic [PREG_W-1:0] t[4];
		int n;
		test_name = "ooo_complete";
		base = PREG_W'($urandom);
		for (int i = 0; i < 4; i++) t[i] = base + PREG_W'(i);
		dispatch_in[0] = make_dispatch(1'b0, t[0]);
		dispatch_in[1] = make_dispatch(1'b0, t[1]);
		tick();
		dispatch_in[0] = make_dispatch(1'b0, t[2]);
		dispatch_in[1] = make_dispatch(1'b0, t[3]);
		tick();
		alu_issue  = '{1'b1, t[3]};  // Youngest
		mult_issue = '{1'b1, t[0]};  // Oldest
		tick();
		n = 0;
		while (model_q.size() == 4) begin
			if (n == 8) report_failure("oldest entry never retired");
			tick();
			n++;
		end
		alu_issue = '{1'b1, t[1]};
		tick();
		alu_issue = '{1'b1, t[2]};
		tick();
		wait_quiet(10);
	endtask

	task automatic measure_latency(input bit use_mult, input int expected);
		logic [PREG_W-1:0] tag;
		int n;
		tag = PREG_W'($urandom);
		bcast_tag.delete();
		if (use_mult) mult_issue = '{1'b1, tag};
		else alu_issue = '{1'b1, tag};
		tick();
		n = 0;
		while (bcast_tag.size() == 0) begin
			if (n == 8) report_failure("issued tag never reached the CDB");
			tick();
			n++;
		end
		check_value(use_mult ? "mult latency" : "alu latency", 32'(expected), 32'(n));
		check_value("latency tag", 32'(tag), 32'(bcast_tag[0]));
	endtask

	task automatic lane_latency();
		logic [PREG_W-1:0] base;
		int first_cyc;
		int n;
		test_name = "lane_latency";
		measure_latency(1'b0, ALU_LATENCY);
		measure_latency(1'b1, MULT_LATENCY);
		base = PREG_W'($urandom);
		bcast_tag.delete();
		bcast_cyc.delete();
		for (int i = 0; i < 3; i++) begin
			mult_issue = '{1'b1, base + PREG_W'(i)};
			tick();
			if (i == 0) first_cyc = cycle_no;
		end
		n = 0;
		while (bcast_tag.size() < 3) begin
			if (n == 8) report_failure("back-to-back multiplies did not all complete");
			tick();
			n++;
		end
		check_value("first mult cycle", 32'(first_cyc + MULT_LATENCY), 32'(bcast_cyc[0]));
		check_value("mult order", 32'(base), 32'(bcast_tag[0]));
		for (int i = 1; i < 3; i++) begin
			check_value("mult spacing", 32'(bcast_cyc[i-1] + 1), 32'(bcast_cyc[i]));
			check_value("mult order", 32'(base + PREG_W'(i)), 32'(bcast_tag[i]));
		end
	endtask

	task automatic arbitration();
		logic [PREG_W-1:0] alu_next;
		logic [PREG_W-1:0] mult_next;
		int total;
		test_name = "arbitration";
		apply_reset();
		alu_next  = 5'd0;   // Integer tags stay below 16
		mult_next = 5'd16;
		alu_stall_seen  = 1'b0;
		mult_stall_seen = 1'b0;
		bcast_tag.delete();
		for (int i = 0; i < 9; i++) begin
			if (i >= 2) alu_issue = '{1'b1, alu_next};
			mult_issue = '{1'b1, mult_next};
			tick();
			if (alu_taken) alu_next++;
			if (mult_taken) mult_next++;
		end
		wait_quiet(30);
		total = int'(alu_next) + int'(mult_next) - 16;
		check_value("broadcast count", 32'(total), 32'(bcast_tag.size()));
		if (bcast_tag.size() < 6) report_failure("too few broadcasts to check alternation");
		for (int k = 0; k < 6; k++) begin
			check_value("winner lane", 32'(k % 2), 32'(bcast_tag[k] >= 5'd16));
		end
		check_value("alu stalled once", 32'(1), 32'(alu_stall_seen));
		check_value("mult stalled once", 32'(1), 32'(mult_stall_seen));
	endtask

	task automatic flush_all();
		logic [PREG_W-1:0] base;
		test_name = "flush_all";
		base = PREG_W'($urandom);
		for (int p = 0; p < 2; p++) begin
			dispatch_in[0] = make_dispatch(1'b0, base + PREG_W'(2 * p));
			dispatch_in[1] = make_dispatch(1'b0, base + PREG_W'(2 * p + 1));
			tick();
		end
		mult_issue = '{1'b1, base};
		alu_issue  = '{1'b1, base + 5'd1};
		tick();
		mult_issue = '{1'b1, base + 5'd2};
		tick();
		alu_issue = '{1'b1, base + 5'd3};  // Both lanes request in the flush cycle
		tick();
		branch_not_taken = 1'b1;
		dispatch_in[0]   = make_dispatch(1'b1, PREG_W'($urandom));  // Flush wins
		tick();
		check_idle();
		repeat (6) tick();  // A stale tag would fail in tick
		check_idle();
	endtask

	task automatic enable_gate();
		test_name = "enable_gate";
		enable = 1'b1;
		dispatch_in[0] = make_dispatch(1'b1, PREG_W'($urandom));
		dispatch_in[1] = make_dispatch(1'b1, PREG_W'($urandom));
		tick();
		enable = 1'b0;
		dispatch_in[0] = make_dispatch(1'b1, PREG_W'($urandom));
		dispatch_in[1] = make_dispatch(1'b1, PREG_W'($urandom));
		tick();
		repeat (3) tick();
		check_value("free rows held", 32'(ROB_SIZE - 2), 32'(free_rows_next));
		enable = 1'b1;
		wait_quiet(4);
		check_idle();
	endtask

	initial begin
		void'($urandom(19));
		failed = 1'b0;
		cycle_no = 0;
		clock = 1'b0;
		rst_n = 1'b0;
		enable = 1'b1;
		branch_not_taken = 1'b0;
		dispatch_in = '0;
		alu_issue = '0;
		mult_issue = '0;
		test_name = "reset";
		apply_reset();
		fill_and_drain();
		ooo_complete();
		lane_latency();
		arbitration();
		flush_all();
		enable_gate();
		if (!failed) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/rob_subsystem.sv ====
`default_nettype none

module rob_subsystem (
	input  wire logic                                      clock,
	input  wire logic                                      rst_n,
	input  wire logic                                      enable,
	input  wire logic                                      branch_not_taken,
	input  wire rob_pkg::dispatch_t [rob_pkg::SS_SIZE-1:0] dispatch_in,
	input  wire rob_pkg::issue_t                           alu_issue,
	input  wire rob_pkg::issue_t                           mult_issue,
	output logic                                           alu_issue_ready,
	output logic                                           mult_issue_ready,
	output rob_pkg::rob_entry_t [rob_pkg::SS_SIZE-1:0]     retire_out,
	output logic [rob_pkg::ROB_IDX_W-1:0]                  free_rows_next,
	output logic                                           full,
	output rob_pkg::cdb_t                                  cdb_out
);
	import rob_pkg::*;

	logic              alu_req;
	logic              mult_req;
	logic              alu_grant;
	logic              mult_grant;
	logic [PREG_W-1:0] alu_tag;
	logic [PREG_W-1:0] mult_tag;

	exec_pipe #(.LATENCY(ALU_LATENCY)) alu_pipe (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (branch_not_taken),
		.issue      (alu_issue),
		.issue_ready(alu_issue_ready),
		.cdb_req    (alu_req),
		.cdb_tag    (alu_tag),
		.cdb_grant  (alu_grant)
	);

	exec_pipe #(.LATENCY(MULT_LATENCY)) mult_pipe (
		.clock      (clock),
		.rst_n      (rst_n),
		.flush      (branch_not_taken),
		.issue      (mult_issue),
		.issue_ready(mult_issue_ready),
		.cdb_req    (mult_req),
		.cdb_tag    (mult_tag),
		.cdb_grant  (mult_grant)
	);

	cdb_arbiter arb0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.alu_req   (alu_req),
		.mult_req  (mult_req),
		.alu_tag   (alu_tag),
		.mult_tag  (mult_tag),
		.alu_grant (alu_grant),
		.mult_grant(mult_grant),
		.cdb       (cdb_out)
	);

	rob rob0 (
		.clock           (clock),
		.rst_n           (rst_n),
		.enable          (enable),
		.branch_not_taken(branch_not_taken),
		.dispatch_in     (dispatch_in),
		.cdb_in          (cdb_out),
		.retire_out      (retire_out),
		.free_rows_next  (free_rows_next),
		.full            (full)
	);

endmodule

`default_nettype wire

// ==== verilog/cdb_arbiter.sv ====
`default_nettype none

module cdb_arbiter (
	input  wire logic                  clock,
	input  wire logic                  rst_n,
	input  wire logic                  alu_req,
	input  wire logic                  mult_req,
	input  wire logic [rob_pkg::PREG_W-1:0] alu_tag,
	input  wire logic [rob_pkg::PREG_W-1:0] mult_tag,
	output logic                       alu_grant,
	output logic                       mult_grant,
	output rob_pkg::cdb_t              cdb
);

	logic last_mult;  // Last winner was the multiply lane

	// On a tie the previous winner steps aside
	assign alu_grant  = alu_req && (!mult_req || last_mult);
	assign mult_grant = mult_req && !alu_grant;

	assign cdb.valid = alu_grant || mult_grant;
	assign cdb.idx   = alu_grant ? alu_tag : mult_tag;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			last_mult <= 1'b1;  // First contest goes to the integer lane
		end else if (alu_grant || mult_grant) begin
			last_mult <= mult_grant;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/exec_pipe.sv ====
`default_nettype none

module exec_pipe #(
	parameter int LATENCY = 1
) (
	input  wire logic                   clock,
	input  wire logic                   rst_n,
	input  wire logic                   flush,
	input  wire rob_pkg::issue_t        issue,
	output logic                        issue_ready,
	output logic                        cdb_req,
	output logic [rob_pkg::PREG_W-1:0]  cdb_tag,
	input  wire logic                   cdb_grant
);
	import rob_pkg::*;

	issue_t [LATENCY-1:0] stage;
	logic                 advance;

	// Tags in flight at a flush are dead, keep them off the bus
	assign cdb_req = stage[LATENCY-1].valid && !flush;
	assign cdb_tag = stage[LATENCY-1].idx;

	assign advance     = !stage[LATENCY-1].valid || cdb_grant;
	assign issue_ready = advance || !stage[0].valid;  // Empty first slot still fills

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			for (int i = 0; i < LATENCY; i++) begin
				stage[i].valid <= 1'b0;
			end
		end else begin
			if (issue_ready) begin
				stage[0] <= issue;
			end
			if (advance) begin
				for (int i = 1; i < LATENCY; i++) begin
					stage[i] <= stage[i-1];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rob.sv ====
`default_nettype none

module rob (
	input  wire logic                                      clock,
	input  wire logic                                      rst_n,
	input  wire logic                                      enable,
	input  wire logic                                      branch_not_taken,
	input  wire rob_pkg::dispatch_t [rob_pkg::SS_SIZE-1:0] dispatch_in,
	input  wire rob_pkg::cdb_t                             cdb_in,
	output rob_pkg::rob_entry_t [rob_pkg::SS_SIZE-1:0]     retire_out,
	output logic [rob_pkg::ROB_IDX_W-1:0]                  free_rows_next,
	output logic                                           full
);
	import rob_pkg::*;

	rob_entry_t [ROB_SIZE-1:0] rob_table;
	rob_entry_t [ROB_SIZE-1:0] rob_table_d;

	logic [ROB_IDX_W-1:0] head;
	logic [ROB_IDX_W-1:0] tail;
	logic [ROB_IDX_W-1:0] head_next;
	logic [ROB_IDX_W-1:0] tail_next;
	logic [ROB_IDX_W-1:0] space;  // Free rows while building next state
	logic [ROB_IDX_W-2:0] row;

	logic [ROB_SIZE-1:0][PREG_W-1:0] new_tags;
	logic [ROB_SIZE-1:0]             hits;
	logic [ROB_SIZE-1:0]             can_retire;
	logic [ROB_SIZE-1:0]             busy_vec;
	logic                            chain;  // Lanes stay in order

	tag_cam cam0 (
		.enable  (cdb_in.valid),
		.tag     (cdb_in.idx),
		.table_in(new_tags),
		.hits    (hits)
	);

	always_comb begin
		for (int i = 0; i < ROB_SIZE; i++) begin
			new_tags[i]   = rob_table[i].t_new.idx;
			busy_vec[i]   = rob_table[i].busy;
			// A broadcast this cycle counts right away
			can_retire[i] = rob_table[i].busy && (rob_table[i].t_new.ready || hits[i]);
		end
	end

	assign full = &busy_vec;

	always_comb begin
		rob_table_d = rob_table;
		head_next   = head;
		tail_next   = tail;

		// Wakeup from the CDB
		for (int i = 0; i < ROB_SIZE; i++) begin
			if (hits[i] && rob_table[i].busy) begin
				rob_table_d[i].t_new.ready = 1'b1;
			end
		end

		// Retire from the head, stop at the first entry still waiting
		chain = enable && !branch_not_taken;
		for (int r = 0; r < SS_SIZE; r++) begin
			retire_out[r]      = '0;
			retire_out[r].inst = NOOP_INST;
			row = head[ROB_IDX_W-2:0] + (ROB_IDX_W-1)'(r);
			if (chain && can_retire[row]) begin
				retire_out[r]          = rob_table_d[row];
				rob_table_d[row].busy  = 1'b0;
				head_next              = head_next + 1'b1;
			end else begin
				chain = 1'b0;
			end
		end

		// Dispatch may reuse rows freed above
		space = ROB_IDX_W'(ROB_SIZE) - (tail - head_next);
		chain = enable && !branch_not_taken;
		for (int d = 0; d < SS_SIZE; d++) begin
			row = tail_next[ROB_IDX_W-2:0];
			if (chain && dispatch_in[d].valid && space != '0) begin
				rob_table_d[row].t_new = dispatch_in[d].t_new;
				rob_table_d[row].t_new.ready = dispatch_in[d].t_new.ready
					|| (cdb_in.valid && cdb_in.idx == dispatch_in[d].t_new.idx);
				rob_table_d[row].t_old = dispatch_in[d].t_old;
				rob_table_d[row].halt  = dispatch_in[d].halt;
				rob_table_d[row].inst  = dispatch_in[d].inst;
				rob_table_d[row].busy  = 1'b1;
				tail_next = tail_next + 1'b1;
				space     = space - 1'b1;
			end else begin
				chain = 1'b0;  // Lane 1 needs lane 0 taken
			end
		end

		if (branch_not_taken) begin
			free_rows_next = ROB_IDX_W'(ROB_SIZE);
		end else begin
			free_rows_next = space;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n || branch_not_taken) begin
			head <= '0;
			tail <= '0;
			for (int i = 0; i < ROB_SIZE; i++) begin
				rob_table[i].busy <= 1'b0;
			end
		end else begin
			head      <= head_next;
			tail      <= tail_next;
			rob_table <= rob_table_d;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/tag_cam.sv ====
`default_nettype none

module tag_cam (
	input  wire logic                                               enable,
	input  wire logic [rob_pkg::PREG_W-1:0]                         tag,
	input  wire logic [rob_pkg::ROB_SIZE-1:0][rob_pkg::PREG_W-1:0] table_in,
	output logic      [rob_pkg::ROB_SIZE-1:0]                       hits
);
	import rob_pkg::*;

	// One comparator per row, all in parallel
	always_comb begin
		for (int i = 0; i < ROB_SIZE; i++) begin
			hits[i] = enable && (table_in[i] == tag);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

	localparam int SS_SIZE      = 2;  // Dispatch and retire width
	localparam int ROB_SIZE     = 8;
	localparam int NUM_PHYS_REG = 32;
	localparam int ROB_IDX_W    = $clog2(ROB_SIZE) + 1;  // Extra wrap bit
	localparam int PREG_W       = $clog2(NUM_PHYS_REG);
	localparam int MULT_LATENCY = 3;
	localparam int ALU_LATENCY  = 1;

	localparam logic [31:0] NOOP_INST = 32'h47ff041f;

	// Ready set means the value exists, no broadcast pending
	typedef struct packed {
		logic              ready;
		logic [PREG_W-1:0] idx;
	} phys_tag_t;

	typedef struct packed {
		phys_tag_t   t_new;
		phys_tag_t   t_old;
		logic        halt;
		logic        busy;
		logic [31:0] inst;
	} rob_entry_t;

	typedef struct packed {
		logic        valid;
		phys_tag_t   t_new;
		phys_tag_t   t_old;
		logic        halt;
		logic [31:0] inst;
	} dispatch_t;

	typedef struct packed {
		logic              valid;
		logic [PREG_W-1:0] idx;
	} cdb_t;

	typedef struct packed {
		logic              valid;
		logic [PREG_W-1:0] idx;
	} issue_t;

endpackage

`default_nettype wire
